//--- Makefile
# Verilator simulation of the store queue testbench
TOP       ?= tb_store_queue
FLIST     ?= flist.f
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass or fail comes from the log, since tee hides the exit status of the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "No errors" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- core_pkg.sv
// Core-wide store operation encoding and the datapath vector types
`default_nettype none

`include "sq_macros.svh"

package core_pkg;

    // Store size carried with every store from decode to memory
    // The top encoding is unused and never allocated
    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } op_t;

    // Destination tag in the ROB, also used to match retirement
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // Byte address computed in the ID stage
    typedef logic [`ADDR_W-1:0] addr_t;

    // Store data, right aligned for SB and SH
    typedef logic [`DATA_W-1:0] data_t;

endpackage

`default_nettype wire

//--- flist.f
+incdir+.
core_pkg.sv
lsu_pkg.sv
sq_entry.sv
sq_launch_ctrl.sv
store_queue.sv
tb_store_queue.sv

//--- lsu_pkg.sv
// Store queue types for entry state, allocation, launch and LSU update
`default_nettype none

`include "sq_macros.svh"

package lsu_pkg;

    import core_pkg::*;

    // Index of one store queue entry
    typedef logic [`SQ_IDX_W-1:0] sq_idx_t;

    // Life of one entry
    // The top bit marks the states that the ROB has already retired
    // VALID is still speculative and can be flushed
    // MHQ_FILL_WAIT parks a store that missed until the MHQ fills the line
    // LAUNCHED holds the one store that is in the LSU pipeline
    typedef enum logic [2:0] {
        INVALID        = 3'b000,
        VALID          = 3'b001,
        MHQ_FILL_WAIT  = 3'b100,
        NONSPECULATIVE = 3'b101,
        LAUNCHED       = 3'b110
    } sq_state_t;

    // Store written into a free entry from decode
    typedef struct packed {
        op_t      op;
        rob_tag_t tag;
        addr_t    addr;
        data_t    data;
    } sq_alloc_t;

    // Store sent to the LSU pipeline on launch
    typedef struct packed {
        op_t      op;
        rob_tag_t tag;
        addr_t    addr;
        data_t    data;
    } sq_retire_t;

    // Outcome of the launched store as reported by the LSU and the MHQ
    typedef struct packed {
        logic retry;
        logic replay;
        logic mhq_retry;
        logic mhq_replay;
        logic done;
    } sq_update_t;

endpackage

`default_nettype wire

//--- sq_entry.sv
// Single store queue entry holding one store and its five-state life cycle
`timescale 1ns/1ps
`default_nettype none

module sq_entry
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       i_rst_n,
    input  wire logic       i_flush,
    // Allocation from decode, steered here by the control block
    input  wire logic       i_alloc_en,
    input  sq_alloc_t       i_alloc,
    // ROB retirement broadcast
    input  wire logic       i_rob_retire_en,
    input  rob_tag_t        i_rob_retire_tag,
    output logic            o_rob_retire_ack,
    // Launch into the LSU pipeline
    input  wire logic       i_retire_en,
    output sq_retire_t      o_retire,
    // Result of the launch, routed only to the launched entry
    input  wire logic       i_update_en,
    input  sq_update_t      i_update,
    // MHQ fill broadcast wakes every waiting store
    input  wire logic       i_mhq_fill_en,
    output logic            o_empty,
    output logic            o_retirable
);

    sq_state_t  state_r;
    sq_state_t  state_next;
    sq_state_t  fill_target;
    sq_state_t  update_target;
    logic [2:0] update_sel;
    sq_alloc_t  payload_r;
    logic       rob_match;

    // Only a speculative entry can be retired by the ROB
    // At most one entry holds a given tag, so at most one entry acks
    assign rob_match = i_rob_retire_en && (state_r == VALID) &&
                       (payload_r.tag == i_rob_retire_tag);

    // A fill in the same cycle as the MHQ retry means the line is already back
    assign fill_target = i_mhq_fill_en ? NONSPECULATIVE : MHQ_FILL_WAIT;

    // Select is {retry, any replay, mhq_retry}
    // Any replay sends the store back for another launch
    // Retry together with mhq_retry waits for the fill
    // Everything else, a plain done included, frees the entry
    assign update_sel = {i_update.retry, i_update.replay | i_update.mhq_replay,
                         i_update.mhq_retry};

    always_comb begin
        casez (update_sel)
            3'b?1?:  update_target = NONSPECULATIVE;
            3'b101:  update_target = fill_target;
            default: update_target = INVALID;
        endcase
    end

    always_comb begin
        state_next = state_r;
        case (state_r)
            INVALID: begin
                if (i_alloc_en) begin
                    state_next = VALID;
                end
            end
            VALID: begin
                // Flush wins over a retirement in the same cycle
                if (i_flush) begin
                    state_next = INVALID;
                end else if (rob_match) begin
                    state_next = NONSPECULATIVE;
                end
            end
            MHQ_FILL_WAIT: begin
                if (i_mhq_fill_en) begin
                    state_next = NONSPECULATIVE;
                end
            end
            NONSPECULATIVE: begin
                if (i_retire_en) begin
                    state_next = LAUNCHED;
                end
            end
            LAUNCHED: begin
                // The pipeline drops the store on flush, so it must launch again
                if (i_flush) begin
                    state_next = NONSPECULATIVE;
                end else if (i_update_en) begin
                    state_next = update_target;
                end
            end
            default: begin
                state_next = INVALID;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_r <= INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Payload is only meaningful once the state leaves INVALID
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            payload_r <= i_alloc;
        end
    end

    assign o_empty          = (state_r == INVALID);
    assign o_retirable      = (state_r == NONSPECULATIVE);
    assign o_rob_retire_ack = rob_match;

    assign o_retire.op   = payload_r.op;
    assign o_retire.tag  = payload_r.tag;
    assign o_retire.addr = payload_r.addr;
    assign o_retire.data = payload_r.data;

    // The control block must only pick a free entry for allocation
    a_alloc_when_free: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_alloc_en |-> state_r == INVALID);

    // The control block must only launch an entry that the ROB retired
    a_launch_when_nonspec: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_retire_en |-> state_r == NONSPECULATIVE);

    // State register stays within the five legal encodings
    a_state_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
        state_r inside {INVALID, VALID, MHQ_FILL_WAIT, NONSPECULATIVE, LAUNCHED});

    // Every update from the LSU names some outcome for the launched store
    a_update_has_outcome: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_update_en |-> (i_update.done || i_update.retry || i_update.replay ||
                         i_update.mhq_replay));

endmodule

`default_nettype wire

//--- sq_launch_ctrl.sv
// Store queue control picking entries for allocation and launch and routing LSU updates
`timescale 1ns/1ps
`default_nettype none

`include "sq_macros.svh"

module sq_launch_ctrl
    import lsu_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_flush,
    input  wire logic                    i_alloc_en,
    input  wire logic                    i_update_en,
    // Status and payload returned by every entry
    input  wire logic [`SQ_ENTRIES-1:0]  i_entry_empty,
    input  wire logic [`SQ_ENTRIES-1:0]  i_entry_retirable,
    input  sq_retire_t                   i_entry_retire [`SQ_ENTRIES],
    // Per-entry strobes, each one-hot or zero
    output logic [`SQ_ENTRIES-1:0]       o_entry_alloc_en,
    output logic [`SQ_ENTRIES-1:0]       o_entry_retire_en,
    output logic [`SQ_ENTRIES-1:0]       o_entry_update_en,
    // Launch port towards the LSU pipeline
    output logic                         o_retire_en,
    output sq_retire_t                   o_retire,
    output logic                         o_empty,
    output logic                         o_full
);

    localparam logic [`SQ_ENTRIES-1:0] ONE = `SQ_ENTRIES'(1);

    logic [`SQ_ENTRIES-1:0] alloc_pick;
    logic [`SQ_ENTRIES-1:0] retire_pick;
    sq_idx_t                launch_idx;
    sq_idx_t                launched_idx_r;
    logic                   in_flight_r;

    // Lowest set bit of a vector is isolated by AND with its two's complement
    // Lower index means higher priority for both pickers
    assign alloc_pick  = i_entry_empty & (~i_entry_empty + ONE);
    assign retire_pick = i_entry_retirable & (~i_entry_retirable + ONE);

    // Encode the launch pick so the payload mux and the tracker share one index
    always_comb begin
        launch_idx = '0;
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            if (retire_pick[i]) begin
                launch_idx = sq_idx_t'(i);
            end
        end
    end

    // A full queue gives an all-zero pick, so the allocation is dropped
    assign o_entry_alloc_en = i_alloc_en ? alloc_pick : '0;

    // Only one store may be in the LSU pipeline at a time
    // Nothing launches during a flush since the pipeline is being cleared
    assign o_retire_en       = (|i_entry_retirable) && !in_flight_r && !i_flush;
    assign o_entry_retire_en = o_retire_en ? retire_pick : '0;
    assign o_retire          = i_entry_retire[launch_idx];

    // The update belongs to the store in flight and to no other entry
    assign o_entry_update_en = (i_update_en && in_flight_r) ? (ONE << launched_idx_r) : '0;

    // In-flight tracker
    // An update ends the launch, and so does a flush which sends it back
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            in_flight_r    <= 1'b0;
            launched_idx_r <= '0;
        end else begin
            if (i_flush || i_update_en) begin
                in_flight_r <= 1'b0;
            end else if (o_retire_en) begin
                in_flight_r <= 1'b1;
            end
            if (o_retire_en) begin
                launched_idx_r <= launch_idx;
            end
        end
    end

    assign o_empty = &i_entry_empty;
    assign o_full  = ~|i_entry_empty;

    // An LSU update with no store in flight has no entry to land on
    a_update_in_flight: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_update_en |-> in_flight_r);

    // Entry strobes never select more than one entry
    a_strobes_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0(o_entry_alloc_en) && $onehot0(o_entry_retire_en));

    // Decode should stall on full, the store is lost otherwise
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_alloc_en |-> !o_full)
        else $warning("store allocated while the store queue is full, dropped");

endmodule

`default_nettype wire

//--- sq_macros.svh
// Store queue sizing and the core datapath widths shared by the packages and the RTL
`ifndef SQ_MACROS_SVH
`define SQ_MACROS_SVH

// Number of store queue entries
// Any value of 2 or more works since the pickers use index priority only
`define SQ_ENTRIES 8

// Width of an entry index, wide enough to name every entry
`define SQ_IDX_W $clog2(`SQ_ENTRIES)

// ROB tag width, sized for a 32 entry reorder buffer
`define ROB_TAG_W 5

// Store address width in bytes
`define ADDR_W 32

// Store data word width
// Byte and half stores use the low bits of the word
`define DATA_W 32

`endif

//--- sq_tests.txt
// One cycle per line: al op tg addr (alloc), fl (flush), rr rt (ROB retire), up uf (update), fi (fill)
// Expected: em fu ak re (empty, full, ack, retire_en), et eaddr (launch tag and address if re)
1 2 01 00001000 0 0 00 0 00 0 1 0 0 0 00 00000000
1 0 02 00001010 0 0 00 0 00 0 0 0 0 0 00 00000000
1 1 03 00001020 0 0 00 0 00 0 0 0 0 0 00 00000000
1 2 04 00001030 0 0 00 0 00 0 0 0 0 0 00 00000000
1 2 05 00001040 0 0 00 0 00 0 0 0 0 0 00 00000000
1 0 06 00001050 0 0 00 0 00 0 0 0 0 0 00 00000000
1 1 07 00001060 0 0 00 0 00 0 0 0 0 0 00 00000000
1 2 08 00001070 0 0 00 0 00 0 0 0 0 0 00 00000000
1 2 09 00001080 0 0 00 0 00 0 0 1 0 0 00 00000000
0 0 00 00000000 0 1 09 0 00 0 0 1 0 0 00 00000000
0 0 00 00000000 0 1 03 0 00 0 0 1 1 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 1 0 1 03 00001020
0 0 00 00000000 0 1 01 0 00 0 0 1 1 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 1 0 0 00 00000000
0 0 00 00000000 0 0 00 1 01 0 0 1 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 01 00001000
0 0 00 00000000 0 0 00 1 08 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 01 00001000
0 0 00 00000000 0 0 00 1 14 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 1 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 01 00001000
0 0 00 00000000 0 0 00 1 14 1 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 01 00001000
0 0 00 00000000 0 0 00 1 01 0 0 0 0 0 00 00000000
0 0 00 00000000 0 1 06 0 00 0 0 0 1 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 06 00001050
0 0 00 00000000 0 1 08 0 00 0 0 0 1 0 00 00000000
0 0 00 00000000 0 1 04 0 00 0 0 0 1 0 00 00000000
0 0 00 00000000 1 0 00 0 00 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 04 00001030
0 0 00 00000000 0 0 00 1 01 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 06 00001050
0 0 00 00000000 0 0 00 1 01 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 0 0 0 1 08 00001070
0 0 00 00000000 0 0 00 1 01 0 0 0 0 0 00 00000000
0 0 00 00000000 0 0 00 0 00 0 1 0 0 0 00 00000000

//--- store_queue.sv
// Store queue top joining the launch control block with the array of entries
`timescale 1ns/1ps
`default_nettype none

`include "sq_macros.svh"

module store_queue
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  i_rst_n,
    // Store allocation from decode
    input  wire logic  i_alloc_en,
    input  sq_alloc_t  i_alloc,
    input  wire logic  i_flush,
    // ROB retirement
    input  wire logic  i_rob_retire_en,
    input  rob_tag_t   i_rob_retire_tag,
    output logic       o_rob_retire_ack,
    // LSU result for the launched store and MHQ fill wakeup
    input  wire logic  i_update_en,
    input  sq_update_t i_update,
    input  wire logic  i_mhq_fill_en,
    // Launch towards the LSU pipeline
    output logic       o_retire_en,
    output sq_retire_t o_retire,
    output logic       o_empty,
    output logic       o_full
);

    logic [`SQ_ENTRIES-1:0] entry_empty;
    logic [`SQ_ENTRIES-1:0] entry_retirable;
    logic [`SQ_ENTRIES-1:0] entry_rob_ack;
    logic [`SQ_ENTRIES-1:0] entry_alloc_en;
    logic [`SQ_ENTRIES-1:0] entry_retire_en;
    logic [`SQ_ENTRIES-1:0] entry_update_en;
    sq_retire_t             entry_retire [`SQ_ENTRIES];

    sq_launch_ctrl ctrl_i (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_flush           (i_flush),
        .i_alloc_en        (i_alloc_en),
        .i_update_en       (i_update_en),
        .i_entry_empty     (entry_empty),
        .i_entry_retirable (entry_retirable),
        .i_entry_retire    (entry_retire),
        .o_entry_alloc_en  (entry_alloc_en),
        .o_entry_retire_en (entry_retire_en),
        .o_entry_update_en (entry_update_en),
        .o_retire_en       (o_retire_en),
        .o_retire          (o_retire),
        .o_empty           (o_empty),
        .o_full            (o_full)
    );

    // Flush, fill, retire tag and the allocation payload reach every entry
    // Only the per-entry strobes from the control block differ
    for (genvar g = 0; g < `SQ_ENTRIES; g++) begin : g_entry
        sq_entry entry_i (
            .clk              (clk),
            .i_rst_n          (i_rst_n),
            .i_flush          (i_flush),
            .i_alloc_en       (entry_alloc_en[g]),
            .i_alloc          (i_alloc),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_rob_retire_ack (entry_rob_ack[g]),
            .i_retire_en      (entry_retire_en[g]),
            .o_retire         (entry_retire[g]),
            .i_update_en      (entry_update_en[g]),
            .i_update         (i_update),
            .i_mhq_fill_en    (i_mhq_fill_en),
            .o_empty          (entry_empty[g]),
            .o_retirable      (entry_retirable[g])
        );
    end

    // At most one entry matches the tag, so the OR is the ack of that entry
    assign o_rob_retire_ack = |entry_rob_ack;

endmodule

`default_nettype wire

//--- tb_store_queue.sv
// Self-checking testbench for the store queue, replaying one cycle per line of a step file
`timescale 1ns/1ps
`default_nettype none

`include "sq_macros.svh"

module tb_store_queue
    import core_pkg::*;
    import lsu_pkg::*;
();

    localparam int          CLK_PERIOD     = 8;
    localparam int          WORDS_PER_STEP = 16;
    localparam int          MAX_STEPS      = 64;
    localparam int          NUM_TAGS       = 2 ** `ROB_TAG_W;
    localparam logic [31:0] SEED           = 32'h8e15_7dc9;
    localparam logic [31:0] NO_WORD        = 32'hffff_ffff;

    logic       clk;
    logic       rst_n;
    logic       alloc_en;
    sq_alloc_t  alloc;
    logic       flush;
    logic       rob_retire_en;
    rob_tag_t   rob_retire_tag;
    logic       rob_retire_ack;
    logic       update_en;
    sq_update_t update;
    logic       mhq_fill_en;
    logic       retire_en;
    sq_retire_t retire;
    logic       empty;
    logic       full;

    // Flat copy of the step file, WORDS_PER_STEP words per cycle
    logic [31:0] test_mem [MAX_STEPS * WORDS_PER_STEP];
    // Payload of each allocated store, looked up by tag when it launches
    data_t       data_by_tag [NUM_TAGS];
    logic [1:0]  op_by_tag [NUM_TAGS];
    int          num_steps;
    int          checks;
    int          errors;
    int          cycle_count;
    int          timeout_limit;

    store_queue dut_i (
        .clk              (clk),
        .i_rst_n          (rst_n),
        .i_alloc_en       (alloc_en),
        .i_alloc          (alloc),
        .i_flush          (flush),
        .i_rob_retire_en  (rob_retire_en),
        .i_rob_retire_tag (rob_retire_tag),
        .o_rob_retire_ack (rob_retire_ack),
        .i_update_en      (update_en),
        .i_update         (update),
        .i_mhq_fill_en    (mhq_fill_en),
        .o_retire_en      (retire_en),
        .o_retire         (retire),
        .o_empty          (empty),
        .o_full           (full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Run limit grows with the number of steps in the file
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare_value(input int step, input string name,
                                 input logic [31:0] got, input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t step %0d: %s got %0h expected %0h",
                     $time, step, name, got, expected);
        end
    endtask

    // Drives one line of stimulus; new store data is drawn here and remembered by tag
    task automatic apply_step(input int step);
        int       base;
        rob_tag_t tag;
        base           = step * WORDS_PER_STEP;
        tag            = test_mem[base + 2][`ROB_TAG_W-1:0];
        alloc_en       = test_mem[base][0];
        alloc.op       = op_t'(test_mem[base + 1][1:0]);
        alloc.tag      = tag;
        alloc.addr     = test_mem[base + 3];
        alloc.data     = $urandom;
        if (alloc_en) begin
            data_by_tag[tag] = alloc.data;
            op_by_tag[tag]   = test_mem[base + 1][1:0];
        end
        flush          = test_mem[base + 4][0];
        rob_retire_en  = test_mem[base + 5][0];
        rob_retire_tag = test_mem[base + 6][`ROB_TAG_W-1:0];
        update_en      = test_mem[base + 7][0];
        update         = sq_update_t'(test_mem[base + 8][4:0]);
        mhq_fill_en    = test_mem[base + 9][0];
    endtask

    task automatic check_step(input int step);
        int       base;
        rob_tag_t etag;
        base = step * WORDS_PER_STEP;
        etag = test_mem[base + 14][`ROB_TAG_W-1:0];
        compare_value(step, "o_empty", 32'(empty), test_mem[base + 10]);
        compare_value(step, "o_full", 32'(full), test_mem[base + 11]);
        compare_value(step, "o_rob_retire_ack", 32'(rob_retire_ack), test_mem[base + 12]);
        compare_value(step, "o_retire_en", 32'(retire_en), test_mem[base + 13]);
        // Launch payload is only defined while the launch strobe is expected
        if (test_mem[base + 13][0]) begin
            compare_value(step, "o_retire.tag", 32'(retire.tag), 32'(etag));
            compare_value(step, "o_retire.addr", retire.addr, test_mem[base + 15]);
            compare_value(step, "o_retire.data", retire.data, data_by_tag[etag]);
            compare_value(step, "o_retire.op", 32'(retire.op), 32'(op_by_tag[etag]));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk            = 1'b0;
        rst_n          = 1'b0;
        alloc_en       = 1'b0;
        alloc          = '0;
        flush          = 1'b0;
        rob_retire_en  = 1'b0;
        rob_retire_tag = '0;
        update_en      = 1'b0;
        update         = '0;
        mhq_fill_en    = 1'b0;
        checks         = 0;
        errors         = 0;
        cycle_count    = 0;
        for (int i = 0; i < MAX_STEPS * WORDS_PER_STEP; i++) begin
            test_mem[i] = NO_WORD;
        end
        $readmemh("sq_tests.txt", test_mem);
        // The first word of a step is the alloc strobe, so the unfilled marker ends the list
        num_steps = 0;
        while (num_steps < MAX_STEPS && test_mem[num_steps * WORDS_PER_STEP] != NO_WORD) begin
            num_steps++;
        end
        timeout_limit = 4 * num_steps + 20;
        if (num_steps == 0) begin
            errors++;
            $display("No test steps could be read from sq_tests.txt");
        end

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Inputs change 1 ns after the edge and outputs are sampled 1 ns before the next
        for (int s = 0; s < num_steps; s++) begin
            apply_step(s);
            #(CLK_PERIOD - 2);
            check_step(s);
            @(posedge clk);
            #1;
        end

        $display("Steps: %0d, checks: %0d, errors: %0d", num_steps, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
